/* run_sim.sh */
#!/bin/sh
# build and run the xbar array testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_xbar_array \
  -f xbar_array.f -o tb_xbar_array
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_xbar_array > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  exit 1
fi
exit 0

/* tb_xbar_array.sv */
`default_nettype none

module tb_xbar_array;
  import xbar_pkg::*;

  localparam int n_lanes  = 4;
  localparam int cap_max  = 2048;  // bits kept per lane
  localparam int wait_max = 1000;  // cycles, well past one 545 cycle program
  localparam int ack_lat  = 2;     // cycles from request to ack, any address

  logic               sclk;
  logic               reset;
  logic               cyc;
  logic               stb;
  logic               we;
  logic [15:0]        adr;
  logic [15:0]        dat_w;
  wire                ack;
  wire  [15:0]        dat_r;
  wire  [n_lanes-1:0] xbar_clock;
  wire  [n_lanes-1:0] pclk;
  wire  [n_lanes-1:0] sin;

  logic [15:0] model [n_lanes][cfg_words];  // expected config words per lane
  logic        cap_bits [n_lanes][cap_max]; // sin while xbar_clock high
  int          cap_cnt   [n_lanes];
  int          pulse_cnt [n_lanes];         // cycles seen with pclk low
  int          pulse_at  [n_lanes];         // bits captured when pclk went low
  int          pulse_cyc [n_lanes];
  int          cyc_n;                       // free running cycle count
  int          err_cnt;
  int          test_cnt;
  int          test_err0;
  logic        timed_out;

  xbar_array_top #(.num_lanes(n_lanes), .base_lane(0)) DUT (.*);

  initial begin
    sclk = 1'b0;
    forever #5 sclk = ~sclk;
  end

  always @(posedge sclk) begin
    cyc_n <= cyc_n + 1;
  end

  // ----------------------------------------
  // serial collector, mid cycle sampling
  // ----------------------------------------
  always @(negedge sclk) begin
    for (int l = 0; l < n_lanes; l++) begin
      if (!reset && xbar_clock[l] && cap_cnt[l] < cap_max) begin
        cap_bits[l][cap_cnt[l]] <= sin[l];
        cap_cnt[l]              <= cap_cnt[l] + 1;
      end
      if (!reset && !pclk[l]) begin  // latch pulse
        pulse_cnt[l] <= pulse_cnt[l] + 1;
        pulse_at[l]  <= cap_cnt[l];
        pulse_cyc[l] <= cyc_n;
      end
    end
  end

  task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (timed_out) return;
    assert (got === exp) else begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_num(input int got, input int exp, input string what);
    if (timed_out) return;
    assert (got == exp) else begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // ----------------------------------------
  // wishbone master
  // ----------------------------------------
  task automatic bus_cycle(input logic wr, input logic [15:0] a, input logic [15:0] d,
                           output logic [15:0] rd);
    int n;
    n  = 0;
    rd = 'x;
    repeat (2) @(posedge sclk);  // gap so the front end is free again
    #1;
    if (timed_out) return;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = wr;
    adr   = a;
    dat_w = d;
    while (!ack && !timed_out) begin
      @(posedge sclk);
      #1;
      n++;
      if (n > 10 && !ack) begin
        $display("no ack from the bus for address %h within 10 cycles", a);
        timed_out = 1'b1;
        err_cnt++;
      end
    end
    check_num(n, ack_lat, $sformatf("ack latency at %h", a));
    rd  = dat_r;  // read data rides with ack
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input logic [15:0] a, input logic [15:0] d);
    logic [15:0] unused_rd;
    bus_cycle(1'b1, a, d, unused_rd);
  endtask

  task automatic wb_read(input logic [15:0] a, output logic [15:0] rd);
    bus_cycle(1'b0, a, 16'h0000, rd);
  endtask

  task automatic cfg_write(input int l, input int w, input logic [15:0] d);
    model[l][w] = d;
    wb_write({8'(l), 8'(w)}, d);
  endtask

  task automatic wait_pulse(input int l, input int target);
    int n;
    n = 0;
    while (!timed_out && pulse_cnt[l] < target) begin
      @(posedge sclk);
      #1;
      n++;
      if (n > wait_max) begin
        $display("lane %0d gave no pclk pulse within %0d cycles", l, wait_max);
        timed_out = 1'b1;
        err_cnt++;
      end
    end
  endtask

  // one full program since base, msb of word 0 first, then one latch
  task automatic check_program(input int l, input int base, input int p0);
    int b;
    int bad;
    bad = -1;
    repeat (3) @(posedge sclk);
    #1;
    check_num(pulse_cnt[l] - p0, 1, $sformatf("lane %0d pclk low cycles", l));
    check_num(cap_cnt[l] - base, 512, $sformatf("lane %0d bits shifted", l));
    check_num(pulse_at[l] - base, 512, $sformatf("lane %0d bits before pclk", l));
    for (b = 0; b < 512 && base + b < cap_max; b++) begin
      if (bad < 0 && cap_bits[l][base + b] !== model[l][b / 16][15 - b % 16]) begin
        bad = b;
      end
    end
    check_num(bad, -1, $sformatf("lane %0d first wrong serial bit", l));
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d checks failed", test_cnt, name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------
  task automatic test_reset_state();
    logic [15:0] rd;
    for (int l = 0; l < n_lanes; l++) begin
      wb_read({8'(l), reg_id}, rd);
      check_word(rd, 16'h7ba2, $sformatf("lane %0d id", l));
      wb_read({8'(l), reg_busy}, rd);
      check_word(rd, 16'h0000, $sformatf("lane %0d busy", l));
    end
    check_word(16'(pclk), 16'h000f, "pclk after reset");
    check_word(16'(xbar_clock), 16'h0000, "xbar_clock after reset");
    check_word(16'(sin), 16'h0000, "sin after reset");
    end_test("reset state");
  endtask

  task automatic test_config_rw();
    logic [15:0] rd;
    for (int l = 0; l < n_lanes; l++) begin
      for (int w = 0; w < cfg_words; w++) begin
        if (l == 1) cfg_write(l, w, 16'($urandom));
        else cfg_write(l, w, {8'(l) ^ 8'h5a, 8'(w * 7 + 3)});  // lane and word in the data
      end
    end
    for (int l = 0; l < n_lanes; l++) begin
      for (int w = 0; w < cfg_words; w++) begin
        wb_read({8'(l), 8'(w)}, rd);
        check_word(rd, model[l][w], $sformatf("lane %0d word %0d", l, w));
      end
    end
    end_test("config readback");
  endtask

  task automatic test_serialize();
    logic [15:0] rd;
    int          base;
    int          p0;
    int          ack_cyc;
    base = cap_cnt[2];
    p0   = pulse_cnt[2];
    wb_write({8'd2, reg_cmd}, 16'h0001);
    ack_cyc = cyc_n;
    wb_read({8'd2, reg_busy}, rd);
    check_word(rd, 16'h0001, "lane 2 busy while shifting");
    wait_pulse(2, p0 + 1);
    check_num(pulse_cyc[2] - ack_cyc, 545, "cycles from command ack to latch");
    check_program(2, base, p0);
    wb_read({8'd2, reg_busy}, rd);
    check_word(rd, 16'h0000, "lane 2 busy after latch");
    end_test("serialize lane 2");
  endtask

  task automatic test_busy_write();
    logic [15:0] rd;
    logic [15:0] old;
    int          base;
    int          p0;
    old  = model[2][5];
    base = cap_cnt[2];
    p0   = pulse_cnt[2];
    wb_write({8'd2, reg_cmd}, 16'h0001);
    wb_write({8'd2, 8'd5}, ~old);  // lane is busy, must be dropped
    wait_pulse(2, p0 + 1);
    check_program(2, base, p0);
    wb_read({8'd2, 8'd5}, rd);
    check_word(rd, old, "lane 2 word 5 after busy write");
    end_test("write while busy");
  endtask

  task automatic test_unmapped();
    logic [15:0] rd;
    int          caps0 [n_lanes];
    int          pulses0 [n_lanes];
    for (int l = 0; l < n_lanes; l++) begin
      caps0[l]   = cap_cnt[l];
      pulses0[l] = pulse_cnt[l];
    end
    wb_read(16'h0922, rd);
    check_word(rd, 16'h0000, "read of lane 9");
    wb_write(16'h0900, 16'hffff);
    wb_write({8'd9, reg_cmd}, 16'h0001);
    wb_read(16'h0900, rd);
    check_word(rd, 16'h0000, "config read of lane 9");
    repeat (20) @(posedge sclk);
    #1;
    for (int l = 0; l < n_lanes; l++) begin
      check_num(cap_cnt[l] - caps0[l], 0, $sformatf("lane %0d bits after miss", l));
      check_num(pulse_cnt[l] - pulses0[l], 0, $sformatf("lane %0d pulses after miss", l));
    end
    check_word(16'(pclk), 16'h000f, "pclk after miss");
    check_word(16'(xbar_clock), 16'h0000, "xbar_clock after miss");
    end_test("unmapped lane");
  endtask

  task automatic test_two_lanes();
    int base0;
    int base3;
    int p0;
    int p3;
    for (int w = 0; w < cfg_words; w++) begin
      cfg_write(0, w, 16'($urandom));
      cfg_write(3, w, 16'($urandom));
    end
    base0 = cap_cnt[0];
    base3 = cap_cnt[3];
    p0    = pulse_cnt[0];
    p3    = pulse_cnt[3];
    wb_write({8'd0, reg_cmd}, 16'h0001);
    wb_write({8'd3, reg_cmd}, 16'h00ff);
    wait_pulse(0, p0 + 1);
    wait_pulse(3, p3 + 1);
    check_program(0, base0, p0);
    check_program(3, base3, p3);
    end_test("two lanes at once");
  endtask

  initial begin
    logic [31:0] rnd;
    rnd       = $urandom(32'hc079_07b2);  // seeds the run
    reset     = 1'b1;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = 16'h0000;
    dat_w     = 16'h0000;
    err_cnt   = 0;
    test_cnt  = 0;
    test_err0 = 0;
    timed_out = 1'b0;
    repeat (5) @(posedge sclk);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_config_rw();
    test_serialize();
    test_busy_write();
    test_unmapped();
    test_two_lanes();
    $display("%0d tests run, %0d checks failed", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wb_lane_decode.sv */
`default_nettype none

module wb_lane_decode #(
  parameter int num_lanes = 4,
  parameter int base_lane = 0
) (
  input  wire                             sclk,
  input  wire                             reset,
  input  wire                             cyc,
  input  wire                             stb,
  input  wire                             we,
  input  wire [xbar_pkg::addr_w-1:0]      adr,
  input  wire [xbar_pkg::word_w-1:0]      dat_w,
  output logic                            miss,   // cycle for an unmapped lane
  xbar_lane_if.host                       lanes [num_lanes]
);
  import xbar_pkg::*;

  logic [lane_w-1:0]    lane_idx;   // lane number relative to base_lane
  logic                 lane_hit;
  logic                 accept;
  logic                 issued;     // req or miss is out this cycle
  logic                 answering;  // ack is on the bus this cycle
  logic                 pending;
  logic                 miss_q;     // miss seen, answer goes out next cycle
  logic [num_lanes-1:0] req_q;
  logic                 we_q;
  logic [reg_w-1:0]     reg_q;
  logic [word_w-1:0]    wdata_q;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // below base_lane wraps to a large index and counts as a miss
  assign lane_idx = adr[reg_w +: lane_w] - lane_w'(base_lane);
  assign lane_hit = int'(lane_idx) < num_lanes;

  // the master holds stb until ack, so block until the answer has gone out
  assign pending = issued | answering;
  assign accept  = cyc & stb & ~pending;

  // ----------------------------------------
  // control, one transaction in flight
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      issued    <= 1'b0;
      answering <= 1'b0;
      miss_q    <= 1'b0;
      miss      <= 1'b0;
      req_q     <= '0;
    end else begin
      issued    <= accept;
      answering <= issued;    // lane or miss ack lands one cycle after req
      miss_q    <= accept & ~lane_hit;
      miss      <= miss_q;    // same slot as a lane ack
      for (int i = 0; i < num_lanes; i++) begin
        req_q[i] <= accept && lane_hit && (lane_idx == lane_w'(i));
      end
    end
  end

  // request payload, captured with the cycle
  always_ff @(posedge sclk) begin
    if (accept) begin
      we_q    <= we;
      reg_q   <= adr[reg_w-1:0];
      wdata_q <= dat_w;
    end
  end

  // fan the request out, only the selected lane sees req
  for (genvar g = 0; g < num_lanes; g++) begin : g_drive
    assign lanes[g].req      = req_q[g];
    assign lanes[g].we       = we_q;
    assign lanes[g].reg_addr = reg_q;
    assign lanes[g].wdata    = wdata_q;
  end

endmodule

`default_nettype wire

/* wb_return_mux.sv */
`default_nettype none

module wb_return_mux #(
  parameter int num_lanes = 4
) (
  input  wire                        sclk,
  input  wire                        reset,
  input  wire                        miss,   // decode answers unmapped lanes itself
  xbar_lane_if.ret                   lanes [num_lanes],
  output logic                       ack,
  output logic [xbar_pkg::word_w-1:0] dat_r
);
  import xbar_pkg::*;

  logic [num_lanes:0] ack_vec;              // lane acks, miss in the top bit
  logic [word_w-1:0]  lane_data [num_lanes];
  logic [word_w-1:0]  data_or;
  logic               collide;              // more than one answer at once
  logic               ack_q;                // bus ack of the last cycle

  // gate each lane's data with its own ack
  for (genvar g = 0; g < num_lanes; g++) begin : g_gather
    assign ack_vec[g]   = lanes[g].ack;
    assign lane_data[g] = lanes[g].rdata & {word_w{lanes[g].ack}};
  end
  assign ack_vec[num_lanes] = miss;  // miss carries no data so reads zero

  always_comb begin
    data_or = '0;
    for (int i = 0; i < num_lanes; i++) begin
      data_or = data_or | lane_data[i];
    end
  end

  // clears the lowest set bit, anything left means two acks
  assign collide = |(ack_vec & (ack_vec - 1'b1));

  // ----------------------------------------
  // duplicate check
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= |ack_vec;
    end
  end

  assign ack   = |ack_vec;
  // a back to back repeat or two answers at once carry no data
  assign dat_r = (collide | (ack_q & ack)) ? '0 : data_or;

endmodule

`default_nettype wire

/* xbar_array.f */
xbar_pkg.sv
xbar_lane_if.sv
wb_lane_decode.sv
xbar_program_engine.sv
wb_return_mux.sv
xbar_array_top.sv
xbar_array_assert.sv
tb_xbar_array.sv

/* xbar_array_assert.sv */
`default_nettype none

module xbar_array_assert #(
  parameter int num_lanes = 4
) (
  input wire                 sclk,
  input wire                 reset,
  input wire                 ack,
  input wire [num_lanes-1:0] xbar_clock,
  input wire [num_lanes-1:0] pclk,
  input wire [num_lanes-1:0] sin
);

  // ----------------------------------------
  // bus
  // ----------------------------------------
  ack_one_cycle: assert property (@(posedge sclk) disable iff (reset) ack |=> !ack)
    else $error("ack high for two cycles in a row");

  // ----------------------------------------
  // crossbar pins, per lane
  // ----------------------------------------
  for (genvar g = 0; g < num_lanes; g++) begin : g_pin
    // latch comes straight after the last shift, never with it
    latch_apart: assert property (@(posedge sclk) disable iff (reset)
      !pclk[g] |-> (!xbar_clock[g] && $past(xbar_clock[g])))
      else $error("lane %0d pclk low outside the cycle after the last shift", g);

    // bit only moves on an edge next to a shift cycle
    sin_steady: assert property (@(posedge sclk) disable iff (reset)
      !$stable(sin[g]) |-> (xbar_clock[g] || $past(xbar_clock[g])))
      else $error("lane %0d sin changed away from a shift cycle", g);
  end

endmodule

bind xbar_array_top xbar_array_assert #(.num_lanes(num_lanes)) u_assert (
  .sclk       (sclk),
  .reset      (reset),
  .ack        (ack),
  .xbar_clock (xbar_clock),
  .pclk       (pclk),
  .sin        (sin)
);

`default_nettype wire

/* xbar_array_top.sv */
`default_nettype none

module xbar_array_top #(
  parameter int num_lanes = 4,
  parameter int base_lane = 0
) (
  input  wire                         sclk,
  input  wire                         reset,
  // wishbone classic slave
  input  wire                         cyc,
  input  wire                         stb,
  input  wire                         we,
  input  wire [xbar_pkg::addr_w-1:0]  adr,    // [15:8] lane, [7:0] register
  input  wire [xbar_pkg::word_w-1:0]  dat_w,
  output wire                         ack,
  output wire [xbar_pkg::word_w-1:0]  dat_r,
  // crossbar pins, one bit per lane
  output wire [num_lanes-1:0]         xbar_clock,
  output wire [num_lanes-1:0]         pclk,
  output wire [num_lanes-1:0]         sin
);

  wire miss;  // unmapped lane, answered by the return path

  xbar_lane_if lane_bus [num_lanes] ();

  // ----------------------------------------
  // front end
  // ----------------------------------------
  wb_lane_decode #(
    .num_lanes (num_lanes),
    .base_lane (base_lane)
  ) u_decode (
    .sclk  (sclk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .miss  (miss),
    .lanes (lane_bus)
  );

  // ----------------------------------------
  // programmer lanes
  // ----------------------------------------
  for (genvar g = 0; g < num_lanes; g++) begin : g_lane
    xbar_program_engine u_engine (
      .sclk       (sclk),
      .reset      (reset),
      .bus        (lane_bus[g]),
      .xbar_clock (xbar_clock[g]),
      .pclk       (pclk[g]),
      .sin        (sin[g])
    );
  end

  // answers back onto the bus
  wb_return_mux #(
    .num_lanes (num_lanes)
  ) u_return (
    .sclk  (sclk),
    .reset (reset),
    .miss  (miss),
    .lanes (lane_bus),
    .ack   (ack),
    .dat_r (dat_r)
  );

endmodule

`default_nettype wire

/* xbar_lane_if.sv */
`default_nettype none

// one request and its answer between front end, lane and return path
interface xbar_lane_if;
  import xbar_pkg::*;

  logic              req;       // single cycle strobe from the front end
  logic              we;        // 1 = write, 0 = read
  logic [reg_w-1:0]  reg_addr;  // register inside the lane
  logic [word_w-1:0] wdata;
  logic              ack;       // one cycle, one cycle after req
  logic [word_w-1:0] rdata;     // valid while ack is high

  // front end side
  modport host (output req, output we, output reg_addr, output wdata);

  // lane side, answers the request
  modport lane (
    input  req,
    input  we,
    input  reg_addr,
    input  wdata,
    output ack,
    output rdata
  );

  // return path only watches the answers
  modport ret (input ack, input rdata);

endinterface

`default_nettype wire

/* xbar_pkg.sv */
`default_nettype none

package xbar_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int word_w    = 16;                // bus data and config word width
  localparam int lane_w    = 8;                 // lane field, adr[15:8]
  localparam int reg_w     = 8;                 // register field, adr[7:0]
  localparam int addr_w    = lane_w + reg_w;    // full wishbone address

  // config store geometry, 32 words of 16 bits make the 512 switch bits
  localparam int cfg_words = 32;
  localparam int cfg_idx_w = 5;                 // log2 of cfg_words
  localparam int bit_idx_w = 4;                 // log2 of word_w, bit within a word
  localparam int cnt_w     = cfg_idx_w + bit_idx_w;  // 9 bit serial bit counter

  // ----------------------------------------
  // register map, per lane
  // ----------------------------------------
  // 0x00..0x1f are the config words, word 0 goes out first
  localparam logic [reg_w-1:0] reg_cmd  = 8'h20;  // non-zero write starts programming
  localparam logic [reg_w-1:0] reg_busy = 8'h21;  // bit 0 is busy
  localparam logic [reg_w-1:0] reg_id   = 8'h22;  // identity word

  localparam logic [word_w-1:0] id_value = 16'h7ba2;  // reads a bit like "xbar"

  // ----------------------------------------
  // serializer fsm
  // ----------------------------------------
  // idle   waits for a command
  // load   one cycle per word, xbar_clock low, word goes into the shift reg
  // shift  16 cycles per word, xbar_clock high, sin carries the msb
  // latch  one cycle with pclk low to set the switches
  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_load  = 2'd1,
    st_shift = 2'd2,
    st_latch = 2'd3
  } engine_state_t;

endpackage

`default_nettype wire

/* xbar_program_engine.sv */
`default_nettype none

module xbar_program_engine (
  input  wire       sclk,
  input  wire       reset,
  xbar_lane_if.lane bus,
  output logic      xbar_clock,  // high while bits shift out
  output logic      pclk,        // active low latch pulse
  output logic      sin          // serial data, msb of word 0 first
);
  import xbar_pkg::*;

  logic [word_w-1:0] cfg_mem [cfg_words];  // 512 switch bits
  logic [word_w-1:0] cmd_q;                // non-zero means start
  engine_state_t     state;
  engine_state_t     state_nxt;
  logic [cnt_w-1:0]  bit_cnt;              // bits shifted so far, 0..511
  logic [word_w-1:0] shreg;
  logic              busy;
  logic              cfg_sel;              // register field hits the config words
  logic              wr_ok;                // write that is taken, lane idle
  logic [word_w-1:0] rd_word;

  assign busy    = (state != st_idle);
  assign cfg_sel = (bus.reg_addr < reg_w'(cfg_words));
  assign wr_ok   = bus.req & bus.we & ~busy;  // writes while busy are acked and dropped

  // ----------------------------------------
  // register access
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.req;  // fixed one cycle answer
    end
  end

  always_ff @(posedge sclk) begin
    if (wr_ok && cfg_sel) begin
      cfg_mem[bus.reg_addr[cfg_idx_w-1:0]] <= bus.wdata;
    end
  end

  // command reg, cleared as the fsm leaves idle
  always_ff @(posedge sclk) begin
    if (reset) begin
      cmd_q <= '0;
    end else if (state == st_idle && cmd_q != '0) begin
      cmd_q <= '0;
    end else if (wr_ok && bus.reg_addr == reg_cmd) begin
      cmd_q <= bus.wdata;
    end
  end

  // read mux
  always_comb begin
    rd_word = '0;  // undefined registers read zero
    if (cfg_sel) begin
      rd_word = cfg_mem[bus.reg_addr[cfg_idx_w-1:0]];
    end else begin
      case (bus.reg_addr)
        reg_cmd:  rd_word = cmd_q;
        reg_busy: rd_word = {{(word_w-1){1'b0}}, busy};
        reg_id:   rd_word = id_value;
        default:  rd_word = '0;
      endcase
    end
  end

  // read data rides with ack, writes answer zero
  always_ff @(posedge sclk) begin
    if (bus.req) begin
      bus.rdata <= bus.we ? '0 : rd_word;
    end
  end

  // ----------------------------------------
  // serializer fsm
  // ----------------------------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (cmd_q != '0) begin
          state_nxt = st_load;  // starts on the cycle after the command ack
        end
      end
      st_load: state_nxt = st_shift;  // one load per word
      st_shift: begin
        if (bit_cnt[bit_idx_w-1:0] == '1) begin  // last bit of this word
          state_nxt = (bit_cnt == '1) ? st_latch : st_load;
        end
      end
      st_latch: state_nxt = st_idle;
      default:  state_nxt = st_idle;
    endcase
  end

  // shift path
  always_ff @(posedge sclk) begin
    if (reset) begin
      bit_cnt <= '0;
      shreg   <= '0;  // keeps sin low out of reset
    end else begin
      case (state)
        st_load: begin
          shreg <= cfg_mem[bit_cnt[cnt_w-1:bit_idx_w]];  // word counter/16
        end
        st_shift: begin
          shreg   <= {shreg[word_w-2:0], 1'b0};  // next bit up to the msb
          bit_cnt <= bit_cnt + 1'b1;             // wraps to 0 after bit 511
        end
        default: begin
          bit_cnt <= '0;
        end
      endcase
    end
  end

  // pins straight from the state reg
  assign xbar_clock = (state == st_shift);
  assign pclk       = (state != st_latch);
  assign sin        = shreg[word_w-1];

endmodule

`default_nettype wire
